// File: verilog.f
+incdir+test
source/fe_pkg.sv
source/rx_iq_capture.sv
source/tx_iq_serializer.sv
source/spi_fanout.sv
source/lock_reset_pulse.sv
source/fe_top.sv
test/tb_fe_top.sv

// File: Bender.yml
package:
  name: fe_frontend

sources:
  # Design, package first
  - files:
      - source/fe_pkg.sv
      - source/rx_iq_capture.sv
      - source/tx_iq_serializer.sv
      - source/spi_fanout.sv
      - source/lock_reset_pulse.sv
      - source/fe_top.sv

  # Testbench
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_fe_top.sv

// File: test/tb_fe_tasks.svh
// Directed front-end tests, xorshift random source
// and mismatch bookkeeping

// Devices with a read line: CLK, DAC, TX_DB, TX_ADC, RX_DB, RX_ADC
localparam logic [8:0] READABLE_MASK = 9'b1_0110_1011;

function automatic logic [31:0] next_random();
   logic [31:0] x;
   x = rng_state;
   x = x ^ (x << 13);
   x = x ^ (x >> 17);
   x = x ^ (x << 5);
   rng_state = x;
   return x;
endfunction

// Lands 1 ns after the rising edge, where inputs change
task automatic next_cycle();
   @(posedge dsp_clk);
   #1;
endtask

task automatic report_mismatch(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
   error_count++;
   $display("MISMATCH %s %s: expected %h, actual %h", test, what, expected, actual);
endtask

task automatic close_test(input string test, input int unsigned errors_before);
   tests_run++;
   if (error_count != errors_before)
   begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", test, error_count - errors_before);
   end
   else
   begin
      $display("test %s: ok", test);
   end
endtask

task automatic check_reset_state();
   int unsigned errors_before;
   errors_before = error_count;
   if (rx_valid_o !== '0)
      report_mismatch("reset", "rx_valid_o", 0, rx_valid_o);
   if (pll_rst_o !== 1'b0)
      report_mismatch("reset", "pll_rst_o", 0, pll_rst_o);
   if (tx_bus_o !== '0)
      report_mismatch("reset", "tx_bus_o", 0, tx_bus_o);
   close_test("reset", errors_before);
endtask

task automatic demux_receive();
   logic [15:0]        iqsel_seq [NUM_CHAN];
   logic [11:0]        i_model [NUM_CHAN];
   fe_pkg::iq_sample_t exp_sample [NUM_CHAN];
   logic [NUM_CHAN-1:0] exp_valid;
   logic [31:0]        r;
   int unsigned        errors_before;
   errors_before = error_count;
   iqsel_seq[0] = 16'hB5A4;  // Both start with an I word and hold Q runs
   iqsel_seq[1] = 16'h6D32;
   for (int n = 0; n < 16; n++)
   begin
      for (int c = 0; c < NUM_CHAN; c++)
      begin
         r = next_random();
         rx_bus_i[c].iqsel = iqsel_seq[c][n];
         rx_bus_i[c].data  = r[11:0];
         exp_valid[c]      = iqsel_seq[c][n];
         if (!iqsel_seq[c][n])
            i_model[c] = r[11:0];
         else
            exp_sample[c] = {2'b00, i_model[c], 2'b00, r[11:0]};  // 12 to 14 bits
      end
      next_cycle();
      if (rx_valid_o !== exp_valid)
         report_mismatch("rx_demux", "rx_valid_o", exp_valid, rx_valid_o);
      for (int c = 0; c < NUM_CHAN; c++)
      begin
         if (exp_valid[c] && rx_sample_o[c] !== exp_sample[c])
            report_mismatch("rx_demux", $sformatf("rx_sample_o[%0d]", c),
                            exp_sample[c], rx_sample_o[c]);
      end
   end
   rx_bus_i = '0;
   next_cycle();
   if (rx_valid_o !== '0)
      report_mismatch("rx_demux", "rx_valid_o idle", 0, rx_valid_o);
   close_test("rx_demux", errors_before);
endtask

task automatic interleave_transmit();
   fe_pkg::iq_dac_t  pair [NUM_CHAN];
   fe_pkg::conv_tx_t exp_word;
   int unsigned      errors_before;
   errors_before = error_count;
   while (tx_load_o !== 1'b1)
      next_cycle();
   for (int n = 0; n < 12; n++)
   begin
      for (int c = 0; c < NUM_CHAN; c++)
      begin
         pair[c]        = next_random();
         tx_sample_i[c] = pair[c];
      end
      next_cycle();
      for (int c = 0; c < NUM_CHAN; c++)
      begin
         exp_word = {1'b0, pair[c].i[11:0]};  // I word, upper bits dropped
         if (tx_bus_o[c] !== exp_word)
            report_mismatch("tx_interleave", $sformatf("tx_bus_o[%0d] I", c),
                            exp_word, tx_bus_o[c]);
      end
      if (tx_load_o !== 1'b0)
         report_mismatch("tx_interleave", "tx_load_o in Q phase", 0, tx_load_o);
      for (int c = 0; c < NUM_CHAN; c++)
      begin
         tx_sample_i[c] = next_random();  // Core moves on after the load edge
      end
      next_cycle();
      for (int c = 0; c < NUM_CHAN; c++)
      begin
         exp_word = {1'b1, pair[c].q[11:0]};
         if (tx_bus_o[c] !== exp_word)
            report_mismatch("tx_interleave", $sformatf("tx_bus_o[%0d] Q", c),
                            exp_word, tx_bus_o[c]);
      end
      if (tx_load_o !== 1'b1)
         report_mismatch("tx_interleave", "tx_load_o in I phase", 1, tx_load_o);
   end
   close_test("tx_interleave", errors_before);
endtask

task automatic route_spi();
   logic [31:0] r;
   logic [8:0]  onehot;
   logic [8:0]  exp_sclk;
   logic [8:0]  exp_mosi;
   int unsigned errors_before;
   errors_before = error_count;
   for (int d = 0; d < 9; d++)
   begin
      onehot = 9'd1 << d;
      r      = next_random();
      for (int k = 0; k < 4; k++)
      begin
         next_cycle();
         spi_sclk_i = r[0] ^ k[0];  // All four clock/data combinations
         spi_mosi_i = r[1] ^ k[1];
         spi_sen_i  = ~onehot;
         #1;
         exp_sclk = spi_sclk_i ? onehot : 9'd0;
         exp_mosi = spi_mosi_i ? onehot : 9'd0;
         if (spi_sclk_o !== exp_sclk)
            report_mismatch("spi_routing", $sformatf("spi_sclk_o dev %0d", d),
                            exp_sclk, spi_sclk_o);
         if (spi_mosi_o !== exp_mosi)
            report_mismatch("spi_routing", $sformatf("spi_mosi_o dev %0d", d),
                            exp_mosi, spi_mosi_o);
      end
   end
   next_cycle();
   spi_sclk_i = 1'b1;
   spi_mosi_i = 1'b1;
   spi_sen_i  = '1;
   #1;
   if (spi_sclk_o !== '0 || spi_mosi_o !== '0)
      report_mismatch("spi_routing", "outputs with no select", 0, {spi_sclk_o, spi_mosi_o});
   close_test("spi_routing", errors_before);
endtask

task automatic combine_reads();
   logic [31:0] r;
   logic        expected;
   int unsigned errors_before;
   errors_before = error_count;
   for (int n = 0; n < 40; n++)
   begin
      r = next_random();
      next_cycle();
      spi_miso_i = r[8:0];
      spi_sen_i  = r[24:16];
      #1;
      expected = |(~r[24:16] & r[8:0] & READABLE_MASK);
      if (spi_miso_o !== expected)
         report_mismatch("read_combine", $sformatf("spi_miso_o step %0d", n),
                         expected, spi_miso_o);
   end
   // Only ADC, TX_DAC and RX_DAC selected, all read lines high
   next_cycle();
   spi_miso_i = '1;
   spi_sen_i  = ~9'b0_1001_0100;
   #1;
   if (spi_miso_o !== 1'b0)
      report_mismatch("read_combine", "spi_miso_o write-only devices", 0, spi_miso_o);
   spi_miso_i = '0;
   spi_sen_i  = '1;
   close_test("read_combine", errors_before);
endtask

task automatic pulse_on_lock_change();
   logic        expected;
   int unsigned errors_before;
   errors_before = error_count;
   for (int e = 0; e < 2; e++)
   begin
      next_cycle();
      clock_ready_i = (e == 0);  // Rise first, then fall
      for (int k = 0; k < 9; k++)
      begin
         next_cycle();
         expected = (k < 5);  // Five cycles from the first edge after the change
         if (pll_rst_o !== expected)
            report_mismatch("lock_pulse", $sformatf("pll_rst_o edge %0d cycle %0d", e, k),
                            expected, pll_rst_o);
      end
   end
   close_test("lock_pulse", errors_before);
endtask

// File: test/tb_fe_top.sv
// Testbench top for the front-end: clock, reset, DUT instance,
// timeout guard and result summary
`timescale 1ns/1ps
`default_nettype none

module tb_fe_top;

   localparam int unsigned NUM_CHAN       = 2;
   localparam int unsigned LOCK_STAGES    = 6;
   localparam int unsigned TIMEOUT_CYCLES = 2000;  // Full test run is a few hundred cycles

   logic dsp_clk;
   logic reset_i;

   fe_pkg::conv_rx_t   [NUM_CHAN-1:0] rx_bus_i;
   fe_pkg::iq_sample_t [NUM_CHAN-1:0] rx_sample_o;
   logic               [NUM_CHAN-1:0] rx_valid_o;
   fe_pkg::iq_dac_t    [NUM_CHAN-1:0] tx_sample_i;
   logic                              tx_load_o;
   fe_pkg::conv_tx_t   [NUM_CHAN-1:0] tx_bus_o;

   logic       spi_sclk_i;
   logic       spi_mosi_i;
   logic [8:0] spi_sen_i;    // Active low
   logic [8:0] spi_sclk_o;
   logic [8:0] spi_mosi_o;
   logic [8:0] spi_miso_i;
   logic       spi_miso_o;

   logic clock_ready_i;
   logic pll_rst_o;

   int unsigned cycle_count  = 0;
   int unsigned tests_run    = 0;
   int unsigned tests_failed = 0;
   int unsigned error_count  = 0;
   logic [31:0] rng_state    = 32'h8163_de1c;  // xorshift state

   fe_top #(
      .NUM_CHAN      (NUM_CHAN),
      .LOCK_STAGES   (LOCK_STAGES)
   ) i_dut (
      .dsp_clk       (dsp_clk),
      .reset_i       (reset_i),
      .rx_bus_i      (rx_bus_i),
      .rx_sample_o   (rx_sample_o),
      .rx_valid_o    (rx_valid_o),
      .tx_sample_i   (tx_sample_i),
      .tx_load_o     (tx_load_o),
      .tx_bus_o      (tx_bus_o),
      .spi_sclk_i    (spi_sclk_i),
      .spi_mosi_i    (spi_mosi_i),
      .spi_sen_i     (spi_sen_i),
      .spi_sclk_o    (spi_sclk_o),
      .spi_mosi_o    (spi_mosi_o),
      .spi_miso_i    (spi_miso_i),
      .spi_miso_o    (spi_miso_o),
      .clock_ready_i (clock_ready_i),
      .pll_rst_o     (pll_rst_o)
   );

   `include "tb_fe_tasks.svh"

   // 10 ns clock
   initial
   begin
      dsp_clk = 1'b0;
      forever
      begin
         #5 dsp_clk = ~dsp_clk;
      end
   end

   // Ends a run that stops making progress
   initial
   begin
      while (cycle_count < TIMEOUT_CYCLES)
      begin
         @(posedge dsp_clk);
         cycle_count++;
      end
      $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("sim failed");
      $finish;
   end

   initial
   begin
      reset_i       = 1'b1;
      rx_bus_i      = '1;     // Busy inputs while reset holds the DUT
      tx_sample_i   = '1;
      spi_sclk_i    = 1'b0;
      spi_mosi_i    = 1'b0;
      spi_sen_i     = '1;     // No device selected
      spi_miso_i    = '0;
      clock_ready_i = 1'b0;

      repeat (13) @(posedge dsp_clk);
      #1 clock_ready_i = 1'b1;  // Mixed lock history unless reset clears it
      repeat (3) @(posedge dsp_clk);
      #1;
      reset_i       = 1'b0;
      rx_bus_i      = '0;
      tx_sample_i   = '0;
      clock_ready_i = 1'b0;

      check_reset_state();
      demux_receive();
      interleave_transmit();
      route_spi();
      combine_reads();
      pulse_on_lock_change();

      $display("tests run %0d, tests failed %0d, errors %0d",
               tests_run, tests_failed, error_count);
      if (tests_failed == 0)
      begin
         $display("sim passed");
      end
      else
      begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: source/fe_top.sv
// Front-end top level: receive capture, transmit serializer,
// SPI fanout and lock-change reset for the LMS converter path
`timescale 1ns/1ps
`default_nettype none

module fe_top #(
   parameter int unsigned NUM_CHAN    = 2,  // Converter channels
   parameter int unsigned LOCK_STAGES = 6   // Lock history depth
) (
   input  wire                                   dsp_clk,
   input  wire                                   reset_i,

   // Receive converter buses and captured samples
   input  fe_pkg::conv_rx_t   [NUM_CHAN-1:0]     rx_bus_i,
   output fe_pkg::iq_sample_t [NUM_CHAN-1:0]     rx_sample_o,
   output logic               [NUM_CHAN-1:0]     rx_valid_o,

   // Transmit pairs from the core and converter buses
   input  fe_pkg::iq_dac_t    [NUM_CHAN-1:0]     tx_sample_i,
   output logic                                  tx_load_o,
   output fe_pkg::conv_tx_t   [NUM_CHAN-1:0]     tx_bus_o,

   // SPI master side and device side
   input  wire                                   spi_sclk_i,
   input  wire                                   spi_mosi_i,
   input  wire                [fe_pkg::DEV_RX_ADC:0] spi_sen_i,
   output logic               [fe_pkg::DEV_RX_ADC:0] spi_sclk_o,
   output logic               [fe_pkg::DEV_RX_ADC:0] spi_mosi_o,
   input  wire                [fe_pkg::DEV_RX_ADC:0] spi_miso_i,
   output logic                                  spi_miso_o,

   // Clock lock and derived reset
   input  wire                                   clock_ready_i,
   output logic                                  pll_rst_o
);

   // Input side

   rx_iq_capture #(
      .NUM_CHAN     (NUM_CHAN)
   ) i_rx_capture (
      .dsp_clk      (dsp_clk),
      .reset_i      (reset_i),
      .rx_bus_i     (rx_bus_i),
      .rx_sample_o  (rx_sample_o),
      .rx_valid_o   (rx_valid_o)
   );

   lock_reset_pulse #(
      .LOCK_STAGES  (LOCK_STAGES)
   ) i_lock_reset (
      .dsp_clk       (dsp_clk),
      .reset_i       (reset_i),
      .clock_ready_i (clock_ready_i),
      .pll_rst_o     (pll_rst_o)
   );

   // Output side

   tx_iq_serializer #(
      .NUM_CHAN     (NUM_CHAN)
   ) i_tx_serializer (
      .dsp_clk      (dsp_clk),
      .reset_i      (reset_i),
      .tx_sample_i  (tx_sample_i),
      .tx_load_o    (tx_load_o),
      .tx_bus_o     (tx_bus_o)
   );

   // Purely combinational, no clock needed
   spi_fanout i_spi_fanout (
      .spi_sclk_i   (spi_sclk_i),
      .spi_mosi_i   (spi_mosi_i),
      .spi_sen_i    (spi_sen_i),
      .spi_sclk_o   (spi_sclk_o),
      .spi_mosi_o   (spi_mosi_o),
      .spi_miso_i   (spi_miso_i),
      .spi_miso_o   (spi_miso_o)
   );

endmodule

`default_nettype wire

// File: source/lock_reset_pulse.sv
// Lock-change reset: synchronizes the clock-lock level and pulses
// a reset while its recent history is mixed
`timescale 1ns/1ps
`default_nettype none

module lock_reset_pulse #(
   parameter int unsigned LOCK_STAGES = 6
) (
   input  wire   dsp_clk,
   input  wire   reset_i,
   input  wire   clock_ready_i,
   output logic  pll_rst_o
);

   // Lock history, newest sample in bit 0
   logic [LOCK_STAGES-1:0] lock_sr;

   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
      begin
         lock_sr <= '0;
      end
      else
      begin
         lock_sr <= {lock_sr[LOCK_STAGES-2:0], clock_ready_i};
      end
   end

   // High on any edge of the lock level until the history settles
   assign pll_rst_o = (|lock_sr) & ~(&lock_sr);

endmodule

`default_nettype wire

// File: source/spi_fanout.sv
// SPI fanout: per-device gating of the shared serial clock and data,
// and select-qualified combining of the device read lines
`timescale 1ns/1ps
`default_nettype none

module spi_fanout (
   input  wire                              spi_sclk_i,
   input  wire                              spi_mosi_i,
   input  wire  [fe_pkg::DEV_RX_ADC:0]      spi_sen_i,   // Active low
   output logic [fe_pkg::DEV_RX_ADC:0]      spi_sclk_o,
   output logic [fe_pkg::DEV_RX_ADC:0]      spi_mosi_o,
   input  wire  [fe_pkg::DEV_RX_ADC:0]      spi_miso_i,
   output logic                             spi_miso_o
);

   // Device is addressed while its select is low
   logic [fe_pkg::DEV_RX_ADC:0] dev_sel;

   // Read lines that may reach the core
   logic [fe_pkg::DEV_RX_ADC:0] miso_gated;

   assign dev_sel = ~spi_sen_i;

   // Idle devices see clock and data parked at zero
   always_comb
   begin
      fe_pkg::spi_dev_e dev;

      for (int d = 0; d <= int'(fe_pkg::DEV_RX_ADC); d++)
      begin
         dev = fe_pkg::spi_dev_e'(d);
         if (dev_sel[dev])
         begin
            spi_sclk_o[dev] = spi_sclk_i;
            spi_mosi_o[dev] = spi_mosi_i;
         end
         else
         begin
            spi_sclk_o[dev] = 1'b0;
            spi_mosi_o[dev] = 1'b0;
         end
      end
   end

   // Write-only devices never drive the read path
   assign miso_gated = dev_sel & spi_miso_i & fe_pkg::SPI_READABLE;
   assign spi_miso_o = |miso_gated;

endmodule

`default_nettype wire

// File: source/tx_iq_serializer.sv
// Transmit serializer: interleaves the I and Q words of each channel
// onto its converter bus, with a load strobe towards the core
`timescale 1ns/1ps
`default_nettype none

module tx_iq_serializer #(
   parameter int unsigned NUM_CHAN = 2
) (
   input  wire                                dsp_clk,
   input  wire                                reset_i,
   input  fe_pkg::iq_dac_t  [NUM_CHAN-1:0]    tx_sample_i,
   output logic                               tx_load_o,
   output fe_pkg::conv_tx_t [NUM_CHAN-1:0]    tx_bus_o
);

   fe_pkg::tx_phase_e phase;

   // Q words kept for the second half of each pair
   logic [fe_pkg::CONV_W-1:0] q_hold [NUM_CHAN];

   // Shared phase for all channels, toggles every cycle
   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
      begin
         phase <= fe_pkg::PHASE_I;
      end
      else
      begin
         case (phase)
            fe_pkg::PHASE_I: phase <= fe_pkg::PHASE_Q;
            default:         phase <= fe_pkg::PHASE_I;
         endcase
      end
   end

   assign tx_load_o = (phase == fe_pkg::PHASE_I);  // Core pair taken this edge

   always_ff @(posedge dsp_clk)
   begin
      if (phase == fe_pkg::PHASE_I)
      begin
         for (int c = 0; c < NUM_CHAN; c++)
         begin
            q_hold[c] <= tx_sample_i[c].q[fe_pkg::CONV_W-1:0];
         end
      end
   end

   // Bus words, upper DAC bits dropped
   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
      begin
         tx_bus_o <= '0;
      end
      else
      begin
         for (int c = 0; c < NUM_CHAN; c++)
         begin
            if (phase == fe_pkg::PHASE_I)
            begin
               tx_bus_o[c].iqsel <= 1'b0;
               tx_bus_o[c].data  <= tx_sample_i[c].i[fe_pkg::CONV_W-1:0];
            end
            else
            begin
               tx_bus_o[c].iqsel <= 1'b1;
               tx_bus_o[c].data  <= q_hold[c];
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: source/rx_iq_capture.sv
// Receive capture: splits each converter bus into I and Q words
// and widens them to the core sample width
`timescale 1ns/1ps
`default_nettype none

module rx_iq_capture #(
   parameter int unsigned NUM_CHAN = 2
) (
   input  wire                                   dsp_clk,
   input  wire                                   reset_i,
   input  fe_pkg::conv_rx_t   [NUM_CHAN-1:0]     rx_bus_i,
   output fe_pkg::iq_sample_t [NUM_CHAN-1:0]     rx_sample_o,
   output logic               [NUM_CHAN-1:0]     rx_valid_o
);

   // Last I word seen on each channel
   logic [fe_pkg::CONV_W-1:0] i_hold [NUM_CHAN];

   // Upper bits of the sample are always zero
   function automatic logic [fe_pkg::SAMPLE_W-1:0] zero_ext(
      input logic [fe_pkg::CONV_W-1:0] word
   );
      return {{(fe_pkg::SAMPLE_W - fe_pkg::CONV_W){1'b0}}, word};
   endfunction

   // Data path
   always_ff @(posedge dsp_clk)
   begin
      for (int c = 0; c < NUM_CHAN; c++)
      begin
         if (rx_bus_i[c].iqsel == 1'b0)
         begin
            i_hold[c] <= rx_bus_i[c].data;  // I word, park it
         end
         else
         begin
            // Q word completes the pair with the held I
            rx_sample_o[c].i <= zero_ext(i_hold[c]);
            rx_sample_o[c].q <= zero_ext(rx_bus_i[c].data);
         end
      end
   end

   // One strobe per Q word, repeated Q words give repeated strobes
   always_ff @(posedge dsp_clk)
   begin
      if (reset_i)
      begin
         rx_valid_o <= '0;
      end
      else
      begin
         for (int c = 0; c < NUM_CHAN; c++)
         begin
            rx_valid_o[c] <= rx_bus_i[c].iqsel;
         end
      end
   end

endmodule

`default_nettype wire

// File: source/fe_pkg.sv
// Front-end package: converter and sample widths, I/Q pair structs,
// SPI device numbering and transmit phase encoding
`default_nettype none

package fe_pkg;

   localparam int unsigned SAMPLE_W = 14;  // Sample width inside the core
   localparam int unsigned CONV_W   = 12;  // LMS converter bus width
   localparam int unsigned DAC_W    = 16;  // Transmit word width from the core

   // Received I/Q pair, zero-extended
   typedef struct packed {
      logic [SAMPLE_W-1:0] i;
      logic [SAMPLE_W-1:0] q;
   } iq_sample_t;

   // Transmit I/Q pair as handed over by the core
   typedef struct packed {
      logic [DAC_W-1:0] i;
      logic [DAC_W-1:0] q;
   } iq_dac_t;

   // One converter bus, iqsel low marks an I word
   typedef struct packed {
      logic              iqsel;
      logic [CONV_W-1:0] data;
   } conv_rx_t;

   typedef struct packed {
      logic              iqsel;
      logic [CONV_W-1:0] data;
   } conv_tx_t;

   // SPI devices in select/clock/data vector order
   typedef enum logic [3:0] {
      DEV_CLK    = 4'd0,
      DEV_DAC    = 4'd1,
      DEV_ADC    = 4'd2,
      DEV_TX_DB  = 4'd3,
      DEV_TX_DAC = 4'd4,
      DEV_TX_ADC = 4'd5,
      DEV_RX_DB  = 4'd6,
      DEV_RX_DAC = 4'd7,
      DEV_RX_ADC = 4'd8
   } spi_dev_e;

   // Devices that drive a read line back
   localparam logic [DEV_RX_ADC:0] SPI_READABLE =
      (9'd1 << DEV_CLK)    | (9'd1 << DEV_DAC)   | (9'd1 << DEV_TX_DB) |
      (9'd1 << DEV_TX_ADC) | (9'd1 << DEV_RX_DB) | (9'd1 << DEV_RX_ADC);

   // Transmit serializer state
   typedef enum logic {
      PHASE_I = 1'b0,
      PHASE_Q = 1'b1
   } tx_phase_e;

endpackage

`default_nettype wire
